/* hdl/amber_sys_pkg.sv */
/*
 * Shared definitions for the Amber bus fabric
 * Wishbone request and response structs, width types,
 * address map, register offsets and the slave select enum
 */

package amber_sys_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int WB_ADR_BITS  = 32;
    localparam int WB_DAT_BITS  = 32;
    localparam int WB_SEL_BITS  = WB_DAT_BITS / 8;
    localparam int EXT_IRQ_BITS = 4;
    localparam int IRQ_VEC_BITS = EXT_IRQ_BITS + 1;

    typedef logic [WB_ADR_BITS-1:0]  wb_adr_t;
    typedef logic [WB_DAT_BITS-1:0]  wb_dat_t;
    typedef logic [WB_SEL_BITS-1:0]  wb_sel_t;

    // Sources in order UART0, UART1, Ethernet MAC, test register
    typedef logic [EXT_IRQ_BITS-1:0] ext_irq_t;
    // External sources plus the timer flag on the top bit
    typedef logic [IRQ_VEC_BITS-1:0] irq_vec_t;

    // Master request, 71 bits
    typedef struct packed {
        wb_adr_t adr;
        wb_sel_t sel;
        logic    we;
        wb_dat_t dat;
        logic    cyc;
        logic    stb;
    } wb_req_t;

    // Slave response, 34 bits
    typedef struct packed {
        wb_dat_t dat;
        logic    ack;
        logic    err;
    } wb_rsp_t;

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    localparam int SLAVE_FIELD_LSB  = 28;
    localparam int SLAVE_FIELD_BITS = WB_ADR_BITS - SLAVE_FIELD_LSB;

    typedef logic [SLAVE_FIELD_BITS-1:0] slave_id_t;

    localparam slave_id_t RAM_BASE_ID   = slave_id_t'(0);
    localparam slave_id_t TIMER_BASE_ID = slave_id_t'(1);
    localparam slave_id_t IC_BASE_ID    = slave_id_t'(2);

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_IC,
        SEL_NONE
    } slave_sel_e;

    // Boot RAM is word addressed, upper bits of the region alias
    localparam int RAM_WORDS    = 256;
    localparam int RAM_ADR_BITS = $clog2(RAM_WORDS);
    localparam int RAM_ADR_LSB  = 2;

    typedef logic [RAM_ADR_BITS-1:0] ram_adr_t;

    // Register word offsets
    localparam int REG_OFS_LSB  = 2;
    localparam int REG_OFS_BITS = 3;

    typedef logic [REG_OFS_BITS-1:0] reg_ofs_t;

    localparam reg_ofs_t TM_LOAD     = reg_ofs_t'(0);
    localparam reg_ofs_t TM_VALUE    = reg_ofs_t'(1);
    localparam reg_ofs_t TM_CTRL     = reg_ofs_t'(2);
    localparam reg_ofs_t TM_CLEAR    = reg_ofs_t'(3);
    localparam reg_ofs_t TM_STATUS   = reg_ofs_t'(4);

    localparam reg_ofs_t IC_STATUS   = reg_ofs_t'(0);
    localparam reg_ofs_t IC_IRQ_SET  = reg_ofs_t'(1);
    localparam reg_ofs_t IC_IRQ_CLR  = reg_ofs_t'(2);
    localparam reg_ofs_t IC_FIRQ_SET = reg_ofs_t'(3);
    localparam reg_ofs_t IC_FIRQ_CLR = reg_ofs_t'(4);

endpackage

/* hdl/wb_arbiter.sv */
/*
 * Two-master Wishbone arbiter
 * Fixed priority for master 0, grant locked for the owner's cycle
 */

`timescale 1ns/1ps

module wb_arbiter (
    input  logic                   i_clk,
    input  logic                   i_rst,

    // Master 0 is the Ethernet DMA, master 1 the processor
    input  amber_sys_pkg::wb_req_t i_m0_req,
    output amber_sys_pkg::wb_rsp_t o_m0_rsp,
    input  amber_sys_pkg::wb_req_t i_m1_req,
    output amber_sys_pkg::wb_rsp_t o_m1_rsp,

    // Towards the decoder
    output amber_sys_pkg::wb_req_t o_req,
    input  amber_sys_pkg::wb_rsp_t i_rsp
);

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_M0,
        OWN_M1
    } owner_e;

    owner_e owner_q;
    owner_e grant;

    // ------------------------------------------------------------
    // Grant selection
    // ------------------------------------------------------------
    // Current owner keeps the bus while it holds cyc
    always_comb begin
        if (owner_q == OWN_M0 && i_m0_req.cyc) begin
            grant = OWN_M0;
        end else if (owner_q == OWN_M1 && i_m1_req.cyc) begin
            grant = OWN_M1;
        end else if (i_m0_req.cyc) begin
            grant = OWN_M0;
        end else if (i_m1_req.cyc) begin
            grant = OWN_M1;
        end else begin
            grant = OWN_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner_q <= OWN_IDLE;
        end else begin
            owner_q <= grant;
        end
    end

    // ------------------------------------------------------------
    // Request and response steering
    // ------------------------------------------------------------
    always_comb begin
        o_req    = '0;
        o_m0_rsp = '0;
        o_m1_rsp = '0;
        case (grant)
            OWN_M0: begin
                o_req    = i_m0_req;
                o_m0_rsp = i_rsp;
            end
            OWN_M1: begin
                o_req    = i_m1_req;
                o_m1_rsp = i_rsp;
            end
            default: begin
                // Bus idle, nothing forwarded
                o_req    = '0;
            end
        endcase
    end

endmodule

/* hdl/wb_decoder.sv */
/*
 * Wishbone address decoder
 * Slave select, per-slave request qualify, response OR
 * and the error responder for unmapped addresses
 */

`timescale 1ns/1ps

module wb_decoder (
    input  logic                   i_clk,
    input  logic                   i_rst,

    input  amber_sys_pkg::wb_req_t i_req,
    output amber_sys_pkg::wb_rsp_t o_rsp,

    output amber_sys_pkg::wb_req_t o_ram_req,
    input  amber_sys_pkg::wb_rsp_t i_ram_rsp,
    output amber_sys_pkg::wb_req_t o_timer_req,
    input  amber_sys_pkg::wb_rsp_t i_timer_rsp,
    output amber_sys_pkg::wb_req_t o_ic_req,
    input  amber_sys_pkg::wb_rsp_t i_ic_rsp
);

    amber_sys_pkg::slave_id_t  slave_id;
    amber_sys_pkg::slave_sel_e sel;
    logic                      err_q;

    // Forward the request, strobes only reach the selected slave
    function automatic amber_sys_pkg::wb_req_t qualify(
        input amber_sys_pkg::wb_req_t req,
        input logic                   hit
    );
        amber_sys_pkg::wb_req_t q;
        q     = req;
        q.cyc = req.cyc & hit;
        q.stb = req.stb & hit;
        return q;
    endfunction

    assign slave_id = i_req.adr[amber_sys_pkg::SLAVE_FIELD_LSB +: amber_sys_pkg::SLAVE_FIELD_BITS];

    always_comb begin
        case (slave_id)
            amber_sys_pkg::RAM_BASE_ID:   sel = amber_sys_pkg::SEL_RAM;
            amber_sys_pkg::TIMER_BASE_ID: sel = amber_sys_pkg::SEL_TIMER;
            amber_sys_pkg::IC_BASE_ID:    sel = amber_sys_pkg::SEL_IC;
            default:                      sel = amber_sys_pkg::SEL_NONE;
        endcase
    end

    assign o_ram_req   = qualify(i_req, sel == amber_sys_pkg::SEL_RAM);
    assign o_timer_req = qualify(i_req, sel == amber_sys_pkg::SEL_TIMER);
    assign o_ic_req    = qualify(i_req, sel == amber_sys_pkg::SEL_IC);

    // ------------------------------------------------------------
    // Error responder, timed like a slave ack
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= i_req.cyc & i_req.stb & (sel == amber_sys_pkg::SEL_NONE) & ~err_q;
        end
    end

    // Only one slave answers at a time, idle slaves drive zeros
    always_comb begin
        o_rsp.dat = i_ram_rsp.dat | i_timer_rsp.dat | i_ic_rsp.dat;
        o_rsp.ack = i_ram_rsp.ack | i_timer_rsp.ack | i_ic_rsp.ack;
        o_rsp.err = i_ram_rsp.err | i_timer_rsp.err | i_ic_rsp.err | err_q;
    end

endmodule

/* hdl/boot_ram.sv */
/*
 * Embedded boot RAM slave
 * Word addressed, byte writes under sel, registered read and ack
 */

`timescale 1ns/1ps

module boot_ram (
    input  logic                   i_clk,
    input  logic                   i_rst,

    input  amber_sys_pkg::wb_req_t i_req,
    output amber_sys_pkg::wb_rsp_t o_rsp
);

    amber_sys_pkg::wb_dat_t  mem [amber_sys_pkg::RAM_WORDS];
    amber_sys_pkg::ram_adr_t word_adr;
    amber_sys_pkg::wb_dat_t  rd_q;
    logic                    ack_q;
    logic                    access;

    assign word_adr = i_req.adr[amber_sys_pkg::RAM_ADR_LSB +: amber_sys_pkg::RAM_ADR_BITS];

    // A held strobe is not served twice
    assign access = i_req.cyc & i_req.stb & ~ack_q;

    // Storage and read port
    always_ff @(posedge i_clk) begin
        if (access && i_req.we) begin
            for (int b = 0; b < amber_sys_pkg::WB_SEL_BITS; b++) begin
                if (i_req.sel[b]) begin
                    mem[word_adr][8*b +: 8] <= i_req.dat[8*b +: 8];
                end
            end
        end
        if (access) begin
            rd_q <= mem[word_adr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign o_rsp.dat = ack_q ? rd_q : '0;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

endmodule

/* hdl/timer_module.sv */
/*
 * Down-counting timer slave
 * Load, value, control, clear and status registers,
 * sticky flag output to the interrupt controller
 */

`timescale 1ns/1ps

module timer_module (
    input  logic                   i_clk,
    input  logic                   i_rst,

    input  amber_sys_pkg::wb_req_t i_req,
    output amber_sys_pkg::wb_rsp_t o_rsp,

    output logic                   o_timer_int
);

    amber_sys_pkg::reg_ofs_t ofs;
    amber_sys_pkg::wb_dat_t  load_q;
    amber_sys_pkg::wb_dat_t  count_q;
    amber_sys_pkg::wb_dat_t  rd_next;
    amber_sys_pkg::wb_dat_t  rd_q;
    logic                    en_q;
    logic                    flag_q;
    logic                    ack_q;
    logic                    access;
    logic                    wr;
    logic                    tick;

    assign ofs    = i_req.adr[amber_sys_pkg::REG_OFS_LSB +: amber_sys_pkg::REG_OFS_BITS];
    assign access = i_req.cyc & i_req.stb & ~ack_q;
    assign wr     = access & i_req.we;

    // Terminal count while running
    assign tick   = en_q & (count_q == '0);

    // ------------------------------------------------------------
    // Counter and flag
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            load_q  <= '0;
            count_q <= '0;
            en_q    <= 1'b0;
            flag_q  <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr && ofs == amber_sys_pkg::TM_LOAD) begin
                load_q <= i_req.dat;
            end
            if (wr && ofs == amber_sys_pkg::TM_CTRL) begin
                en_q <= i_req.dat[0];
            end
            // A new load value restarts the period
            if (wr && ofs == amber_sys_pkg::TM_LOAD) begin
                count_q <= i_req.dat;
            end else if (tick) begin
                count_q <= load_q;
            end else if (en_q) begin
                count_q <= count_q - 1'b1;
            end
            // New event beats a clear in the same cycle
            flag_q <= tick | (flag_q & ~(wr && ofs == amber_sys_pkg::TM_CLEAR));
        end
    end

    // Register read
    always_comb begin
        case (ofs)
            amber_sys_pkg::TM_LOAD:   rd_next = load_q;
            amber_sys_pkg::TM_VALUE:  rd_next = count_q;
            amber_sys_pkg::TM_CTRL:   rd_next = {{(amber_sys_pkg::WB_DAT_BITS-1){1'b0}}, en_q};
            amber_sys_pkg::TM_STATUS: rd_next = {{(amber_sys_pkg::WB_DAT_BITS-1){1'b0}}, flag_q};
            default:                  rd_next = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rd_q <= rd_next;
        end
    end

    assign o_rsp.dat   = ack_q ? rd_q : '0;
    assign o_rsp.ack   = ack_q;
    assign o_rsp.err   = 1'b0;
    assign o_timer_int = flag_q;

endmodule

/* hdl/interrupt_controller.sv */
/*
 * Interrupt controller slave
 * Raw status, irq and firq enable registers with set/clear writes
 */

`timescale 1ns/1ps

module interrupt_controller (
    input  logic                    i_clk,
    input  logic                    i_rst,

    input  amber_sys_pkg::wb_req_t  i_req,
    output amber_sys_pkg::wb_rsp_t  o_rsp,

    // Level sources
    input  amber_sys_pkg::ext_irq_t i_ext_irq,
    input  logic                    i_timer_int,

    output logic                    o_irq,
    output logic                    o_firq
);

    amber_sys_pkg::irq_vec_t status;
    amber_sys_pkg::irq_vec_t irq_en_q;
    amber_sys_pkg::irq_vec_t firq_en_q;
    amber_sys_pkg::irq_vec_t wr_bits;
    amber_sys_pkg::reg_ofs_t ofs;
    amber_sys_pkg::wb_dat_t  rd_next;
    amber_sys_pkg::wb_dat_t  rd_q;
    logic                    ack_q;
    logic                    access;
    logic                    wr;

    // Timer flag sits above the external sources
    assign status  = {i_timer_int, i_ext_irq};

    assign ofs     = i_req.adr[amber_sys_pkg::REG_OFS_LSB +: amber_sys_pkg::REG_OFS_BITS];
    assign access  = i_req.cyc & i_req.stb & ~ack_q;
    assign wr      = access & i_req.we;
    assign wr_bits = i_req.dat[amber_sys_pkg::IRQ_VEC_BITS-1:0];

    // ------------------------------------------------------------
    // Enable registers
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            irq_en_q  <= '0;
            firq_en_q <= '0;
            ack_q     <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr) begin
                case (ofs)
                    amber_sys_pkg::IC_IRQ_SET:  irq_en_q  <= irq_en_q | wr_bits;
                    amber_sys_pkg::IC_IRQ_CLR:  irq_en_q  <= irq_en_q & ~wr_bits;
                    amber_sys_pkg::IC_FIRQ_SET: firq_en_q <= firq_en_q | wr_bits;
                    amber_sys_pkg::IC_FIRQ_CLR: firq_en_q <= firq_en_q & ~wr_bits;
                    default: begin
                    end
                endcase
            end
        end
    end

    // Set offsets read back the enables
    always_comb begin
        rd_next = '0;
        case (ofs)
            amber_sys_pkg::IC_STATUS:   rd_next[amber_sys_pkg::IRQ_VEC_BITS-1:0] = status;
            amber_sys_pkg::IC_IRQ_SET:  rd_next[amber_sys_pkg::IRQ_VEC_BITS-1:0] = irq_en_q;
            amber_sys_pkg::IC_FIRQ_SET: rd_next[amber_sys_pkg::IRQ_VEC_BITS-1:0] = firq_en_q;
            default:                    rd_next = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            rd_q <= rd_next;
        end
    end

    assign o_rsp.dat = ack_q ? rd_q : '0;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

    // Masked sources straight to the core
    assign o_irq  = |(status & irq_en_q);
    assign o_firq = |(status & firq_en_q);

endmodule

/* hdl/amber_fabric.sv */
/*
 * Amber bus fabric top level
 * Arbiter, decoder, boot RAM, timer and interrupt controller
 */

`timescale 1ns/1ps

module amber_fabric (
    input  logic                    i_clk,
    input  logic                    i_rst,

    // Master 0 Ethernet DMA, master 1 processor
    input  amber_sys_pkg::wb_req_t  i_m0_req,
    output amber_sys_pkg::wb_rsp_t  o_m0_rsp,
    input  amber_sys_pkg::wb_req_t  i_m1_req,
    output amber_sys_pkg::wb_rsp_t  o_m1_rsp,

    input  amber_sys_pkg::ext_irq_t i_ext_irq,
    output logic                    o_irq,
    output logic                    o_firq
);

    amber_sys_pkg::wb_req_t bus_req;
    amber_sys_pkg::wb_rsp_t bus_rsp;
    amber_sys_pkg::wb_req_t ram_req;
    amber_sys_pkg::wb_rsp_t ram_rsp;
    amber_sys_pkg::wb_req_t timer_req;
    amber_sys_pkg::wb_rsp_t timer_rsp;
    amber_sys_pkg::wb_req_t ic_req;
    amber_sys_pkg::wb_rsp_t ic_rsp;
    logic                   timer_int;

    // ------------------------------------------------------------
    // Bus infrastructure
    // ------------------------------------------------------------
    wb_arbiter u_wb_arbiter (
        .i_clk       ( i_clk     ),
        .i_rst       ( i_rst     ),
        .i_m0_req    ( i_m0_req  ),
        .o_m0_rsp    ( o_m0_rsp  ),
        .i_m1_req    ( i_m1_req  ),
        .o_m1_rsp    ( o_m1_rsp  ),
        .o_req       ( bus_req   ),
        .i_rsp       ( bus_rsp   )
    );

    wb_decoder u_wb_decoder (
        .i_clk       ( i_clk     ),
        .i_rst       ( i_rst     ),
        .i_req       ( bus_req   ),
        .o_rsp       ( bus_rsp   ),
        .o_ram_req   ( ram_req   ),
        .i_ram_rsp   ( ram_rsp   ),
        .o_timer_req ( timer_req ),
        .i_timer_rsp ( timer_rsp ),
        .o_ic_req    ( ic_req    ),
        .i_ic_rsp    ( ic_rsp    )
    );

    // ------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------
    boot_ram u_boot_ram (
        .i_clk       ( i_clk     ),
        .i_rst       ( i_rst     ),
        .i_req       ( ram_req   ),
        .o_rsp       ( ram_rsp   )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk     ),
        .i_rst       ( i_rst     ),
        .i_req       ( timer_req ),
        .o_rsp       ( timer_rsp ),
        .o_timer_int ( timer_int )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk       ( i_clk     ),
        .i_rst       ( i_rst     ),
        .i_req       ( ic_req    ),
        .o_rsp       ( ic_rsp    ),
        .i_ext_irq   ( i_ext_irq ),
        .i_timer_int ( timer_int ),
        .o_irq       ( o_irq     ),
        .o_firq      ( o_firq    )
    );

endmodule

/* dv/tb_clk_gen.sv */
/*
 * Testbench clock and reset generator
 * 20 ns clock, reset held for 16 cycles and released on a falling edge
 */

`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD = 10;
    localparam int RST_CYCLES  = 16;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

/* dv/amber_fabric_chk.sv */
/*
 * Protocol checker bound to the fabric top level
 * Response exclusivity, spacing and strobe qualification per master port
 */

`timescale 1ns/1ps

module amber_fabric_chk (
    input logic                   i_clk,
    input logic                   i_rst,
    input amber_sys_pkg::wb_req_t i_m0_req,
    input amber_sys_pkg::wb_req_t i_m1_req,
    input amber_sys_pkg::wb_rsp_t o_m0_rsp,
    input amber_sys_pkg::wb_rsp_t o_m1_rsp
);

    logic m0_done;
    logic m1_done;

    assign m0_done = o_m0_rsp.ack | o_m0_rsp.err;
    assign m1_done = o_m1_rsp.ack | o_m1_rsp.err;

    // Sampled mid-cycle, where masters hold their request steady
    // ------------------------------------------------------------
    a_m0_excl : assert property (@(negedge i_clk) disable iff (i_rst)
        !(o_m0_rsp.ack && o_m0_rsp.err))
        else $error("master 0 saw ack and err together");
    a_m1_excl : assert property (@(negedge i_clk) disable iff (i_rst)
        !(o_m1_rsp.ack && o_m1_rsp.err))
        else $error("master 1 saw ack and err together");

    a_m0_single : assert property (@(negedge i_clk) disable iff (i_rst)
        m0_done |=> !m0_done)
        else $error("master 0 response in two consecutive cycles");
    a_m1_single : assert property (@(negedge i_clk) disable iff (i_rst)
        m1_done |=> !m1_done)
        else $error("master 1 response in two consecutive cycles");

    a_m0_stb : assert property (@(negedge i_clk) disable iff (i_rst)
        m0_done |-> i_m0_req.stb)
        else $error("master 0 response without strobe");
    a_m1_stb : assert property (@(negedge i_clk) disable iff (i_rst)
        m1_done |-> i_m1_req.stb)
        else $error("master 1 response without strobe");

endmodule

/* dv/tb_amber_fabric.sv */
/*
 * Testbench for the Amber bus fabric
 * Two bus functional masters, RAM and register model, random stimulus,
 * reset, RAM, contention, unmapped, interrupt and timer tests
 */

`timescale 1ns/1ps

module tb_amber_fabric;

    localparam int N_RAM    = 200;
    localparam int N_CONT   = 60;
    localparam int N_UNMAP  = 40;
    localparam int N_IRQ    = 40;
    localparam int N_TRANS  = 256 + N_RAM + 4 * N_CONT + 128 + 2 * N_UNMAP + 4 * N_IRQ + 16;
    localparam int CYCLE_LIMIT = N_TRANS * 8 + 60 + 400;

    logic                    clk;
    logic                    rst;
    amber_sys_pkg::wb_req_t  m0_req;
    amber_sys_pkg::wb_req_t  m1_req;
    amber_sys_pkg::wb_rsp_t  m0_rsp;
    amber_sys_pkg::wb_rsp_t  m1_rsp;
    amber_sys_pkg::ext_irq_t ext_irq;
    logic                    irq;
    logic                    firq;

    int                      seed = 32'hb86640c2;
    int                      checks;
    int                      errors;
    int                      cycles;

    // Reference model state
    amber_sys_pkg::wb_dat_t  ram_model [256];
    amber_sys_pkg::irq_vec_t irq_en_model;
    amber_sys_pkg::irq_vec_t firq_en_model;

    tb_clk_gen u_tb_clk_gen (
        .o_clk ( clk ),
        .o_rst ( rst )
    );

    amber_fabric i_amber_fabric (
        .i_clk     ( clk     ),
        .i_rst     ( rst     ),
        .i_m0_req  ( m0_req  ),
        .o_m0_rsp  ( m0_rsp  ),
        .i_m1_req  ( m1_req  ),
        .o_m1_rsp  ( m1_rsp  ),
        .i_ext_irq ( ext_irq ),
        .o_irq     ( irq     ),
        .o_firq    ( firq    )
    );

    bind amber_fabric amber_fabric_chk u_amber_fabric_chk (
        .i_clk    ( i_clk    ),
        .i_rst    ( i_rst    ),
        .i_m0_req ( i_m0_req ),
        .i_m1_req ( i_m1_req ),
        .o_m0_rsp ( o_m0_rsp ),
        .o_m1_rsp ( o_m1_rsp )
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic amber_sys_pkg::wb_adr_t reg_addr(input logic [3:0] id,
                                                        input logic [2:0] ofs);
        return {id, 23'b0, ofs, 2'b00};
    endfunction

    // Byte lanes not selected keep the old value
    function automatic amber_sys_pkg::wb_dat_t merge_bytes(input logic [31:0] old,
                                                           input logic [31:0] nw,
                                                           input logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    // Single classic cycle, request on a falling edge, held until ack or err
    task automatic bus_cycle(input int m, input amber_sys_pkg::wb_adr_t adr, input logic we,
                             input amber_sys_pkg::wb_sel_t sel, input amber_sys_pkg::wb_dat_t wdat,
                             output amber_sys_pkg::wb_dat_t rdat, output logic got_err);
        amber_sys_pkg::wb_req_t r;
        amber_sys_pkg::wb_rsp_t rsp;
        logic                   done;
        r.adr = adr;
        r.sel = sel;
        r.we  = we;
        r.dat = wdat;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        @(negedge clk);
        if (m == 0) m0_req = r;
        else m1_req = r;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            rsp  = (m == 0) ? m0_rsp : m1_rsp;
            done = rsp.ack | rsp.err;
        end
        rdat    = rsp.dat;
        got_err = rsp.err;
        @(negedge clk);
        if (m == 0) m0_req = '0;
        else m1_req = '0;
    endtask

    task automatic ram_write(input int m, input int idx, input logic [3:0] sel,
                             input logic [31:0] d);
        amber_sys_pkg::wb_dat_t rd;
        logic                   e;
        logic [17:0]            alias_bits;
        alias_bits = 18'($random(seed));
        bus_cycle(m, {4'h0, alias_bits, idx[7:0], 2'b00}, 1'b1, sel, d, rd, e);
        compare("RAM write err", 32'(e), 32'd0);
        ram_model[idx] = merge_bytes(ram_model[idx], d, sel);
    endtask

    task automatic ram_read_check(input int m, input int idx);
        amber_sys_pkg::wb_dat_t rd;
        logic                   e;
        bus_cycle(m, {4'h0, 18'($random(seed)), idx[7:0], 2'b00}, 1'b0, 4'hf, '0, rd, e);
        compare("RAM read err", 32'(e), 32'd0);
        compare("RAM read data", rd, ram_model[idx]);
    endtask

    task automatic reg_write(input logic [3:0] id, input logic [2:0] ofs, input logic [31:0] d);
        amber_sys_pkg::wb_dat_t rd;
        logic                   e;
        bus_cycle(1, reg_addr(id, ofs), 1'b1, 4'hf, d, rd, e);
        compare("register write err", 32'(e), 32'd0);
    endtask

    task automatic reg_read_check(input string what, input logic [3:0] id, input logic [2:0] ofs,
                                  input logic [31:0] exp);
        amber_sys_pkg::wb_dat_t rd;
        logic                   e;
        bus_cycle(1, reg_addr(id, ofs), 1'b0, 4'hf, '0, rd, e);
        compare("register read err", 32'(e), 32'd0);
        compare(what, rd, exp);
    endtask

    task automatic idle_check();
        compare("idle m0 ack/err", {30'd0, m0_rsp.ack, m0_rsp.err}, 32'd0);
        compare("idle m1 ack/err", {30'd0, m1_rsp.ack, m1_rsp.err}, 32'd0);
        compare("idle irq/firq", {30'd0, irq, firq}, 32'd0);
    endtask

    task automatic contention_rounds(input int m);
        int          idx;
        logic [31:0] d;
        repeat (N_CONT) begin
            idx = m * 128 + ($unsigned($random(seed)) % 128);
            d   = $random(seed);
            ram_write(m, idx, 4'($random(seed)), d);
            ram_read_check(m, idx);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int                      idx;
        int                      m;
        int                      load;
        int                      waited;
        logic [3:0]              id;
        logic [2:0]              op;
        logic [4:0]              bits;
        amber_sys_pkg::wb_adr_t  adr;
        amber_sys_pkg::wb_dat_t  rd;
        logic                    e;
        m0_req  = '0;
        m1_req  = '0;
        ext_irq = '0;
        checks  = 0;
        errors  = 0;
        cycles  = 0;
        irq_en_model  = '0;
        firq_en_model = '0;

        // Reset state, once the first edge has cleared the registers
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
            idle_check();
            @(posedge clk);
        end
        repeat (2) begin
            @(negedge clk);
            idle_check();
        end

        // Fill the RAM so every word has a known value
        for (int i = 0; i < 256; i++) begin
            ram_model[i] = '0;
            ram_write(i % 2, i, 4'hf, $random(seed));
        end

        // Random RAM traffic from either master
        repeat (N_RAM) begin
            m   = $unsigned($random(seed)) % 2;
            idx = $unsigned($random(seed)) % 256;
            if ($random(seed) & 1) ram_write(m, idx, 4'($random(seed)), $random(seed));
            else ram_read_check(m, idx);
        end

        // Master 0 owns words 0..127, master 1 owns 128..255
        fork
            contention_rounds(0);
            contention_rounds(1);
        join
        for (int i = 0; i < 128; i++) ram_read_check(1, i);

        // Unmapped slave field must give err and write nothing
        repeat (N_UNMAP) begin
            id  = 4'(3 + ($unsigned($random(seed)) % 13));
            adr = {id, 28'($random(seed))};
            m   = $unsigned($random(seed)) % 2;
            bus_cycle(m, adr, 1'b1, 4'hf, $random(seed), rd, e);
            compare("unmapped err", 32'(e), 32'd1);
            compare("unmapped data", rd, 32'd0);
            ram_read_check(m, adr[9:2]);
        end

        // Interrupt masking against the model
        repeat (N_IRQ) begin
            @(negedge clk);
            ext_irq = 4'($random(seed));
            op      = 3'(1 + ($unsigned($random(seed)) % 4));
            bits    = 5'($random(seed));
            reg_write(4'd2, op, {27'd0, bits});
            case (op)
                3'd1: irq_en_model  = irq_en_model | bits;
                3'd2: irq_en_model  = irq_en_model & ~bits;
                3'd3: firq_en_model = firq_en_model | bits;
                default: firq_en_model = firq_en_model & ~bits;
            endcase
            reg_read_check("IC status", 4'd2, 3'd0, {27'd0, 1'b0, ext_irq});
            reg_read_check("IC irq enable", 4'd2, 3'd1, {27'd0, irq_en_model});
            reg_read_check("IC firq enable", 4'd2, 3'd3, {27'd0, firq_en_model});
            compare("irq output", 32'(irq), 32'(|({1'b0, ext_irq} & irq_en_model)));
            compare("firq output", 32'(firq), 32'(|({1'b0, ext_irq} & firq_en_model)));
        end

        // Timer, external sources masked, only the timer bit enabled
        reg_write(4'd2, 3'd2, 32'h1f);
        reg_write(4'd2, 3'd4, 32'h1f);
        reg_write(4'd2, 3'd1, 32'h10);
        load = 4 + ($unsigned($random(seed)) % 37);
        reg_write(4'd1, 3'd0, load);
        reg_write(4'd1, 3'd2, 32'd1);
        waited = 0;
        while (!irq && waited < load + 4) begin
            @(negedge clk);
            waited++;
        end
        compare("timer irq within L+4 cycles", 32'(irq), 32'd1);
        reg_read_check("timer status set", 4'd1, 3'd4, 32'd1);
        rd = {27'd0, 1'b1, ext_irq};
        reg_read_check("IC status timer bit", 4'd2, 3'd0, rd);

        // Long reload keeps the next event away while clearing
        reg_write(4'd1, 3'd0, 32'd1000);
        reg_write(4'd1, 3'd3, 32'd1);
        reg_write(4'd1, 3'd2, 32'd0);
        reg_read_check("timer status cleared", 4'd1, 3'd4, 32'd0);
        compare("irq after clear", 32'(irq), 32'd0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/amber_sys_pkg.sv
hdl/wb_arbiter.sv
hdl/wb_decoder.sv
hdl/boot_ram.sv
hdl/timer_module.sv
hdl/interrupt_controller.sv
hdl/amber_fabric.sv
dv/tb_clk_gen.sv
dv/amber_fabric_chk.sv
dv/tb_amber_fabric.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_amber_fabric \
    && ./obj_dir/Vtb_amber_fabric | tee /dev/stderr | grep -q "^Simulation PASSED$" \
    && echo "run.sh: test run passed" \
    || { echo "run.sh: test run failed"; exit 1; }
